// File: shift_pkg.sv
// Widths, opcode enums and payload structs shared by every block of the issue and execute slice.
package shift_pkg;

	localparam int XLEN = 64;
	localparam int REG_NUM = 32;
	localparam int REG_AW = $clog2(REG_NUM);
	localparam int ISSUE_DEPTH = 4;
	localparam int ISSUE_IW = $clog2(ISSUE_DEPTH);
	localparam int FUN_W = 2; // holds either function enum.

	typedef enum logic {
		OP_SHIFT = 1'b0,
		OP_LOGIC = 1'b1
	} op_class_e;

	typedef enum logic [FUN_W-1:0] {
		FUN_SLL = 2'd0,
		FUN_SRL = 2'd1,
		FUN_SRA = 2'd2
	} shift_fun_e;

	typedef enum logic [FUN_W-1:0] {
		FUN_AND = 2'd0,
		FUN_OR = 2'd1,
		FUN_XOR = 2'd2
	} logic_fun_e;

	typedef struct packed {
		op_class_e op_class;
		logic [FUN_W-1:0] fun;
		logic is32;
		logic use_imm;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [XLEN-1:0] imm; // sign extended, low 6 bits are shamt for shifts.
	} instr_t;

	typedef struct packed {
		shift_fun_e fun;
		logic is32;
		logic use_imm;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [XLEN-1:0] imm;
	} shift_info_t;

	typedef struct packed {
		logic_fun_e fun;
		logic use_imm;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [XLEN-1:0] imm;
	} logic_info_t;

	typedef struct packed {
		shift_fun_e fun;
		logic is32;
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] op2;
	} shift_exeparam_t;

	typedef struct packed {
		logic [REG_AW-1:0] rd;
		logic [XLEN-1:0] data;
	} wb_t;

endpackage

// File: issue_buffer.sv
// Issue queue of ISSUE_DEPTH slots, filled at the lowest free slot and freed by index on pop.
module issue_buffer #(
	parameter type payload_t = logic
) (
	input logic CLK,
	input logic rst,
	input logic push,
	input payload_t push_data,
	output logic full,
	input logic pop,
	input logic [shift_pkg::ISSUE_IW-1:0] pop_index,
	output payload_t entries [shift_pkg::ISSUE_DEPTH],
	output logic [shift_pkg::ISSUE_DEPTH-1:0] malloc
);

	import shift_pkg::*;

	logic [ISSUE_IW-1:0] free_idx;
	logic push_ok;

	assign full = &malloc;
	assign push_ok = push & ~full;

	// lowest free slot wins.
	always_comb begin
		free_idx = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (!malloc[i]) begin
				free_idx = ISSUE_IW'(i);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			malloc <= '0;
		end else begin
			if (pop) begin
				malloc[pop_index] <= 1'b0;
			end
			if (push_ok) begin
				malloc[free_idx] <= 1'b1; // never the popped slot, it is still marked busy.
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (push_ok) begin
			entries[free_idx] <= push_data;
		end
	end

endmodule

// File: dispatch_scoreboard.sv
// Register file and ready bits, accepts dispatches and routes each one to the shift or logic queue.
module dispatch_scoreboard (
	input logic CLK,
	input logic rst,
	input logic dispatch_valid,
	input shift_pkg::instr_t dispatch_instr,
	output logic dispatch_ready,
	output logic shift_push,
	output shift_pkg::shift_info_t shift_push_data,
	input logic shift_full,
	output logic logic_push,
	output shift_pkg::logic_info_t logic_push_data,
	input logic logic_full,
	output logic [shift_pkg::XLEN-1:0] regs [shift_pkg::REG_NUM],
	output logic [shift_pkg::REG_NUM-1:0] reg_ready,
	input logic wb_valid,
	input shift_pkg::wb_t wb
);

	import shift_pkg::*;

	logic live;
	logic rd_free;
	logic target_full;
	logic fire;
	logic wb_write;

	assign rd_free = (dispatch_instr.rd == '0) | reg_ready[dispatch_instr.rd];
	assign target_full = (dispatch_instr.op_class == OP_SHIFT) ? shift_full : logic_full;
	assign dispatch_ready = live & rd_free & ~target_full; // busy rd stalls, no WAW.
	assign fire = dispatch_valid & dispatch_ready;
	assign wb_write = wb_valid & (wb.rd != '0);

	assign shift_push = fire & (dispatch_instr.op_class == OP_SHIFT);
	assign logic_push = fire & (dispatch_instr.op_class == OP_LOGIC);

	always_comb begin
		shift_push_data.fun = shift_fun_e'(dispatch_instr.fun);
		shift_push_data.is32 = dispatch_instr.is32;
		shift_push_data.use_imm = dispatch_instr.use_imm;
		shift_push_data.rd = dispatch_instr.rd;
		shift_push_data.rs1 = dispatch_instr.rs1;
		shift_push_data.rs2 = dispatch_instr.rs2;
		shift_push_data.imm = dispatch_instr.imm;

		logic_push_data.fun = logic_fun_e'(dispatch_instr.fun);
		logic_push_data.use_imm = dispatch_instr.use_imm;
		logic_push_data.rd = dispatch_instr.rd;
		logic_push_data.rs1 = dispatch_instr.rs1;
		logic_push_data.rs2 = dispatch_instr.rs2;
		logic_push_data.imm = dispatch_instr.imm;
	end

	// dispatch opens one cycle after reset is released.
	always_ff @(posedge CLK) begin
		if (rst) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			reg_ready <= '1;
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wb_write) begin
				regs[wb.rd] <= wb.data;
				reg_ready[wb.rd] <= 1'b1;
			end
			if (fire && dispatch_instr.rd != '0) begin
				reg_ready[dispatch_instr.rd] <= 1'b0; // x0 stays ready.
			end
		end
	end

endmodule

// File: shift_issue.sv
// Shift issue stage that picks the lowest ready slot and registers its execute bundle.
module shift_issue (
	input logic CLK,
	input logic rst,
	input shift_pkg::shift_info_t entries [shift_pkg::ISSUE_DEPTH],
	input logic [shift_pkg::ISSUE_DEPTH-1:0] malloc,
	input logic [shift_pkg::XLEN-1:0] regs [shift_pkg::REG_NUM],
	input logic [shift_pkg::REG_NUM-1:0] reg_ready,
	output logic pop,
	output logic [shift_pkg::ISSUE_IW-1:0] pop_index,
	output logic exe_valid,
	output shift_pkg::shift_exeparam_t exe_param,
	input logic exe_ready
);

	import shift_pkg::*;

	logic [ISSUE_DEPTH-1:0] ready_mask;
	logic any_ready;
	shift_info_t sel;
	shift_exeparam_t param_nxt;

	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			ready_mask[i] = malloc[i] & reg_ready[entries[i].rs1]
				& (entries[i].use_imm | reg_ready[entries[i].rs2]);
		end
	end

	// priority encode, lowest index first.
	always_comb begin
		pop_index = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (ready_mask[i]) begin
				pop_index = ISSUE_IW'(i);
			end
		end
	end

	assign any_ready = |ready_mask;
	assign pop = any_ready & exe_ready;
	assign sel = entries[pop_index];

	always_comb begin
		param_nxt.fun = sel.fun;
		param_nxt.is32 = sel.is32;
		param_nxt.rd = sel.rd;
		param_nxt.op1 = regs[sel.rs1];
		param_nxt.op2 = sel.use_imm ? sel.imm : {{(XLEN-6){1'b0}}, regs[sel.rs2][5:0]};
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			exe_valid <= 1'b0;
		end else if (exe_ready) begin
			exe_valid <= any_ready;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_param <= param_nxt; // held while the lane is stalled.
		end
	end

endmodule

// File: shift_exe.sv
// Shift lane that computes 64- or 32-bit shifts and holds the result until writeback is granted.
module shift_exe (
	input logic CLK,
	input logic rst,
	input logic exe_valid,
	input shift_pkg::shift_exeparam_t exe_param,
	output logic exe_ready,
	output logic req,
	output shift_pkg::wb_t result,
	input logic gnt
);

	import shift_pkg::*;

	logic [5:0] shamt;
	logic [4:0] shamt_w;
	logic [XLEN-1:0] res64;
	logic [31:0] res32;
	logic [XLEN-1:0] res;
	logic take;

	assign shamt = exe_param.op2[5:0];
	assign shamt_w = exe_param.op2[4:0];
	assign exe_ready = ~req | gnt;
	assign take = exe_valid & exe_ready;

	always_comb begin
		case (exe_param.fun)
			FUN_SRL: begin
				res64 = exe_param.op1 >> shamt;
				res32 = exe_param.op1[31:0] >> shamt_w; // zero fill.
			end
			FUN_SRA: begin
				res64 = $signed(exe_param.op1) >>> shamt;
				res32 = $signed(exe_param.op1[31:0]) >>> shamt_w; // fills with bit 31.
			end
			default: begin
				res64 = exe_param.op1 << shamt;
				res32 = exe_param.op1[31:0] << shamt_w;
			end
		endcase
		res = exe_param.is32 ? {{32{res32[31]}}, res32} : res64;
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			req <= 1'b0;
		end else if (take) begin
			req <= 1'b1;
		end else if (gnt) begin
			req <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			result.rd <= exe_param.rd;
			result.data <= res;
		end
	end

endmodule

// File: logic_issue.sv
// Logic lane that selects a ready slot and computes and/or/xor straight into its result register.
module logic_issue (
	input logic CLK,
	input logic rst,
	input shift_pkg::logic_info_t entries [shift_pkg::ISSUE_DEPTH],
	input logic [shift_pkg::ISSUE_DEPTH-1:0] malloc,
	input logic [shift_pkg::XLEN-1:0] regs [shift_pkg::REG_NUM],
	input logic [shift_pkg::REG_NUM-1:0] reg_ready,
	output logic pop,
	output logic [shift_pkg::ISSUE_IW-1:0] pop_index,
	output logic req,
	output shift_pkg::wb_t result,
	input logic gnt
);

	import shift_pkg::*;

	logic [ISSUE_DEPTH-1:0] ready_mask;
	logic_info_t sel;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] res;

	always_comb begin
		for (int i = 0; i < ISSUE_DEPTH; i++) begin
			ready_mask[i] = malloc[i] & reg_ready[entries[i].rs1]
				& (entries[i].use_imm | reg_ready[entries[i].rs2]);
		end
	end

	always_comb begin
		pop_index = '0;
		for (int i = ISSUE_DEPTH - 1; i >= 0; i--) begin
			if (ready_mask[i]) begin
				pop_index = ISSUE_IW'(i);
			end
		end
	end

	assign pop = (|ready_mask) & (~req | gnt); // result register free or leaving.
	assign sel = entries[pop_index];
	assign op_a = regs[sel.rs1];
	assign op_b = sel.use_imm ? sel.imm : regs[sel.rs2];

	always_comb begin
		case (sel.fun)
			FUN_OR: res = op_a | op_b;
			FUN_XOR: res = op_a ^ op_b;
			default: res = op_a & op_b;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			req <= 1'b0;
		end else if (pop) begin
			req <= 1'b1;
		end else if (gnt) begin
			req <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			result.rd <= sel.rd;
			result.data <= res;
		end
	end

endmodule

// File: wb_arbiter.sv
// Round-robin arbiter that shares the single writeback bus between the shift and logic lanes.
module wb_arbiter (
	input logic CLK,
	input logic rst,
	input logic shift_req,
	input shift_pkg::wb_t shift_result,
	output logic shift_gnt,
	input logic logic_req,
	input shift_pkg::wb_t logic_result,
	output logic logic_gnt,
	output logic wb_valid,
	output shift_pkg::wb_t wb
);

	logic last_logic;

	// on a tie the lane that lost last time goes first.
	assign shift_gnt = shift_req & (~logic_req | last_logic);
	assign logic_gnt = logic_req & (~shift_req | ~last_logic);
	assign wb_valid = shift_req | logic_req;
	assign wb = shift_gnt ? shift_result : logic_result;

	always_ff @(posedge CLK) begin
		if (rst) begin
			last_logic <= 1'b0;
		end else if (wb_valid) begin
			last_logic <= logic_gnt;
		end
	end

endmodule

// File: exe_top.sv
// Top level of the slice that wires dispatch, both issue queues, both lanes and the writeback arbiter.
module exe_top (
	input logic CLK,
	input logic rst,
	input logic dispatch_valid,
	input shift_pkg::instr_t dispatch_instr,
	output logic dispatch_ready,
	output logic wb_valid,
	output shift_pkg::wb_t wb
);

	import shift_pkg::*;

	logic [XLEN-1:0] regs [REG_NUM];
	logic [REG_NUM-1:0] reg_ready;

	logic shift_push;
	logic shift_full;
	logic shift_pop;
	logic [ISSUE_IW-1:0] shift_pop_index;
	logic [ISSUE_DEPTH-1:0] shift_malloc;
	shift_info_t shift_push_data;
	shift_info_t shift_entries [ISSUE_DEPTH];

	logic logic_push;
	logic logic_full;
	logic logic_pop;
	logic [ISSUE_IW-1:0] logic_pop_index;
	logic [ISSUE_DEPTH-1:0] logic_malloc;
	logic_info_t logic_push_data;
	logic_info_t logic_entries [ISSUE_DEPTH];

	logic exe_valid;
	logic exe_ready;
	shift_exeparam_t exe_param;

	logic shift_req;
	logic shift_gnt;
	logic logic_req;
	logic logic_gnt;
	wb_t shift_result;
	wb_t logic_result;

	dispatch_scoreboard u_scoreboard (
		.CLK(CLK), .rst(rst),
		.dispatch_valid(dispatch_valid), .dispatch_instr(dispatch_instr),
		.dispatch_ready(dispatch_ready),
		.shift_push(shift_push), .shift_push_data(shift_push_data), .shift_full(shift_full),
		.logic_push(logic_push), .logic_push_data(logic_push_data), .logic_full(logic_full),
		.regs(regs), .reg_ready(reg_ready),
		.wb_valid(wb_valid), .wb(wb)
	);

	issue_buffer #(.payload_t(shift_info_t)) u_shift_buf (
		.CLK(CLK), .rst(rst),
		.push(shift_push), .push_data(shift_push_data), .full(shift_full),
		.pop(shift_pop), .pop_index(shift_pop_index),
		.entries(shift_entries), .malloc(shift_malloc)
	);

	issue_buffer #(.payload_t(logic_info_t)) u_logic_buf (
		.CLK(CLK), .rst(rst),
		.push(logic_push), .push_data(logic_push_data), .full(logic_full),
		.pop(logic_pop), .pop_index(logic_pop_index),
		.entries(logic_entries), .malloc(logic_malloc)
	);

	shift_issue u_shift_issue (
		.CLK(CLK), .rst(rst),
		.entries(shift_entries), .malloc(shift_malloc),
		.regs(regs), .reg_ready(reg_ready),
		.pop(shift_pop), .pop_index(shift_pop_index),
		.exe_valid(exe_valid), .exe_param(exe_param), .exe_ready(exe_ready)
	);

	shift_exe u_shift_exe (
		.CLK(CLK), .rst(rst),
		.exe_valid(exe_valid), .exe_param(exe_param), .exe_ready(exe_ready),
		.req(shift_req), .result(shift_result), .gnt(shift_gnt)
	);

	logic_issue u_logic_issue (
		.CLK(CLK), .rst(rst),
		.entries(logic_entries), .malloc(logic_malloc),
		.regs(regs), .reg_ready(reg_ready),
		.pop(logic_pop), .pop_index(logic_pop_index),
		.req(logic_req), .result(logic_result), .gnt(logic_gnt)
	);

	wb_arbiter u_wb_arbiter (
		.CLK(CLK), .rst(rst),
		.shift_req(shift_req), .shift_result(shift_result), .shift_gnt(shift_gnt),
		.logic_req(logic_req), .logic_result(logic_result), .logic_gnt(logic_gnt),
		.wb_valid(wb_valid), .wb(wb)
	);

endmodule

// File: tb_exe_top.sv
// Self-checking testbench for exe_top that runs random instruction batches against a shadow model.
module tb_exe_top;

	timeunit 1ns;
	timeprecision 1ps;

	import shift_pkg::*;

	localparam int MAX_WAIT = 200;
	localparam int NUM_BATCHES = 60;
	localparam int BATCH_MAX = 6;

	logic CLK;
	logic rst;
	logic dispatch_valid;
	instr_t dispatch_instr;
	logic dispatch_ready;
	logic wb_valid;
	wb_t wb;

	logic [XLEN-1:0] shadow [REG_NUM];
	logic [XLEN-1:0] expect_val [REG_NUM];
	logic [REG_NUM-1:0] pending;
	logic [REG_NUM-1:0] lane_logic; // lane that owns each pending rd.
	logic started;
	int shift_losses;
	int logic_losses;

	exe_top u_dut (
		.CLK(CLK),
		.rst(rst),
		.dispatch_valid(dispatch_valid),
		.dispatch_instr(dispatch_instr),
		.dispatch_ready(dispatch_ready),
		.wb_valid(wb_valid),
		.wb(wb)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic flag_mismatch(input string msg);
		abort_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
	endtask

	// result as the ISA defines it for the already selected operands a and b.
	function automatic logic [XLEN-1:0] ref_result(input instr_t ins, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		logic [XLEN-1:0] out;
		logic [31:0] w;
		logic [63:0] wide_w;
		logic [127:0] wide;
		int sh;
		sh = ins.is32 ? int'(b[4:0]) : int'(b[5:0]);
		out = '0;
		if (ins.op_class == OP_LOGIC) begin
			if (ins.fun == FUN_OR)
				out = a | b;
			else if (ins.fun == FUN_XOR)
				out = a ^ b;
			else
				out = a & b;
		end else if (ins.is32) begin
			if (ins.fun == FUN_SRL) begin
				w = a[31:0] >> sh;
			end else if (ins.fun == FUN_SRA) begin
				wide_w = {{32{a[31]}}, a[31:0]} >> sh;
				w = wide_w[31:0];
			end else begin
				w = a[31:0] << sh;
			end
			out = {{32{w[31]}}, w};
		end else begin
			if (ins.fun == FUN_SRL) begin
				out = a >> sh;
			end else if (ins.fun == FUN_SRA) begin
				wide = {{64{a[63]}}, a} >> sh;
				out = wide[63:0];
			end else begin
				out = a << sh;
			end
		end
		return out;
	endfunction

	// blocked holds every rd and every source used so far in the batch.
	task automatic make_instr(inout logic [REG_NUM-1:0] blocked, output instr_t ins,
			output logic ok);
		logic [31:0] r;
		int start;
		int cand;
		ins = '0;
		r = $urandom;
		ins.op_class = op_class_e'(r[0]);
		ins.use_imm = r[1];
		ins.is32 = (r[0] == 1'b0) ? r[2] : 1'b0;
		ins.fun = r[4:3] % 2'd3;
		ins.rs1 = REG_AW'($urandom_range(REG_NUM - 1));
		ins.rs2 = REG_AW'($urandom_range(REG_NUM - 1));
		ins.imm = {{52{r[31]}}, r[31:20]};
		blocked[ins.rs1] = 1'b1;
		if (!ins.use_imm) begin
			blocked[ins.rs2] = 1'b1;
		end
		start = $urandom_range(REG_NUM - 1, 1);
		ok = 1'b0;
		for (int k = 0; k < REG_NUM - 1; k++) begin
			cand = 1 + (start - 1 + k) % (REG_NUM - 1);
			if (!ok && !blocked[cand]) begin
				ins.rd = REG_AW'(cand);
				ok = 1'b1;
			end
		end
		if (ok) begin
			blocked[ins.rd] = 1'b1;
		end
	endtask

	// called on a rising edge and returns on the edge of the transfer.
	task automatic send_instr(input instr_t ins, output int stalls);
		int waited;
		dispatch_valid <= 1'b1;
		dispatch_instr <= ins;
		waited = 0;
		@(negedge CLK);
		while (!dispatch_ready) begin
			waited++;
			if (waited > MAX_WAIT)
				abort_run("timeout: dispatch_ready never rose for the waiting instruction");
			@(negedge CLK);
		end
		@(posedge CLK);
		stalls = waited;
	endtask

	task automatic drain_batch();
		int waited;
		waited = 0;
		@(posedge CLK);
		while (pending != '0) begin
			waited++;
			if (waited > MAX_WAIT)
				abort_run("timeout: the batch did not drain, some writebacks never came");
			@(posedge CLK);
		end
	endtask

	// writeback checks come before the accepted dispatch enters the model.
	always @(negedge CLK) begin
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] val;
		logic win_logic;
		if (rst) begin
			for (int i = 0; i < REG_NUM; i++) begin
				shadow[i] = '0;
				expect_val[i] = '0;
			end
			pending = '0;
			lane_logic = '0;
			started = 1'b0;
			shift_losses = 0;
			logic_losses = 0;
		end else begin
			if (dispatch_valid && dispatch_ready) begin
				waw_free: assert (!pending[dispatch_instr.rd])
					else flag_mismatch($sformatf("dispatch accepted while x%0d is busy",
						dispatch_instr.rd));
			end
			if (wb_valid) begin
				wb_known: assert (pending[wb.rd])
					else flag_mismatch($sformatf("writeback to x%0d with nothing pending", wb.rd));
				wb_data: assert (wb.data == expect_val[wb.rd])
					else flag_mismatch($sformatf("x%0d got %h, expected %h", wb.rd, wb.data,
						expect_val[wb.rd]));
				win_logic = lane_logic[wb.rd];
				wb_lane: assert (win_logic ? u_dut.logic_req : u_dut.shift_req)
					else flag_mismatch($sformatf("x%0d written back by a lane not requesting", wb.rd));
				if (u_dut.shift_req)
					shift_losses = win_logic ? shift_losses + 1 : 0;
				if (u_dut.logic_req)
					logic_losses = win_logic ? 0 : logic_losses + 1;
				fair: assert (shift_losses <= 1 && logic_losses <= 1)
					else flag_mismatch("a requesting lane lost arbitration twice in a row");
				pending[wb.rd] = 1'b0;
			end
			if (dispatch_valid && dispatch_ready) begin
				a = shadow[dispatch_instr.rs1];
				b = dispatch_instr.use_imm ? dispatch_instr.imm : shadow[dispatch_instr.rs2];
				val = ref_result(dispatch_instr, a, b);
				if (dispatch_instr.rd != '0) begin
					shadow[dispatch_instr.rd] = val;
					expect_val[dispatch_instr.rd] = val;
					pending[dispatch_instr.rd] = 1'b1;
					lane_logic[dispatch_instr.rd] = (dispatch_instr.op_class == OP_LOGIC);
				end
				started = 1'b1;
			end
		end
	end

	ready_after_rst: assert property (@(posedge CLK) $fell(rst) |-> !dispatch_ready)
		else flag_mismatch("dispatch_ready high in the first cycle after reset");
	no_early_wb: assert property (@(posedge CLK) disable iff (rst) !started |-> !wb_valid)
		else flag_mismatch("writeback appeared before the first dispatch");
	wb_no_x: assert property (@(posedge CLK) disable iff (rst) wb_valid |-> !$isunknown(wb))
		else flag_mismatch("writeback carries unknown bits");

	initial begin
		instr_t ins;
		logic [REG_NUM-1:0] blocked;
		logic ok;
		int stalls;
		int len;
		int waited;
		void'($urandom(53969));
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_instr = '0;
		repeat (2) @(posedge CLK);
		rst <= 1'b0;

		waited = 0;
		@(negedge CLK);
		while (!dispatch_ready) begin
			idle_wb: assert (!wb_valid) else flag_mismatch("writeback seen while idle after reset");
			waited++;
			if (waited > MAX_WAIT)
				abort_run("timeout: dispatch_ready did not rise after reset");
			@(negedge CLK);
		end
		@(posedge CLK);

		// fill every register with xori from x0.
		for (int r = 1; r < REG_NUM; r++) begin
			ins = '0;
			ins.op_class = OP_LOGIC;
			ins.fun = FUN_XOR;
			ins.use_imm = 1'b1;
			ins.rd = REG_AW'(r);
			ins.imm = {{52{r[0]}}, 12'($urandom)};
			send_instr(ins, stalls);
		end
		dispatch_valid <= 1'b0;
		drain_batch();

		for (int bt = 0; bt < NUM_BATCHES; bt++) begin
			blocked = '0;
			len = $urandom_range(BATCH_MAX, 2);
			for (int k = 0; k < len; k++) begin
				make_instr(blocked, ins, ok);
				if (ok) begin
					send_instr(ins, stalls);
				end
			end
			dispatch_valid <= 1'b0;
			drain_batch();
		end

		// back to back writes of x5 by logic, logic and shift.
		ins = '0;
		ins.op_class = OP_LOGIC;
		ins.fun = FUN_OR;
		ins.rd = 5'd5;
		ins.rs1 = 5'd3;
		ins.rs2 = 5'd4;
		send_instr(ins, stalls);
		ins.fun = FUN_XOR;
		ins.use_imm = 1'b1;
		ins.rs1 = 5'd6;
		ins.imm = {{52{1'b1}}, 12'h9a5};
		send_instr(ins, stalls);
		busy_stall_1: assert (stalls > 0)
			else flag_mismatch("second write of x5 was accepted without waiting");
		ins = '0;
		ins.op_class = OP_SHIFT;
		ins.fun = FUN_SRA;
		ins.is32 = 1'b1;
		ins.rd = 5'd5;
		ins.rs1 = 5'd7;
		ins.rs2 = 5'd8;
		send_instr(ins, stalls);
		busy_stall_2: assert (stalls > 0)
			else flag_mismatch("third write of x5 was accepted without waiting");
		dispatch_valid <= 1'b0;
		drain_batch();

		$display("test passed");
		$finish;
	end

endmodule

// File: sim.f
shift_pkg.sv
issue_buffer.sv
dispatch_scoreboard.sv
shift_issue.sv
shift_exe.sv
logic_issue.sv
wb_arbiter.sv
exe_top.sv
tb_exe_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_exe_top
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "FAIL: no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
